// ==== sobel_macros.svh ====
// Sizes, limits and APB register offsets for the edge filter, included by RTL and testbench.
`ifndef SOBEL_MACROS_SVH
`define SOBEL_MACROS_SVH

// one memory line is 64 pixels of 8 bits.
`define SOBEL_LINE_BITS 512

// line FIFO depth, which is also the read credit limit.
`define SOBEL_FIFO_DEPTH 16

// writes allowed in flight on the memory write channel.
`define SOBEL_MAX_WRITES 8

// APB byte offsets.
`define SOBEL_REG_CONTROL 8'h00
`define SOBEL_REG_SRC     8'h04
`define SOBEL_REG_DST     8'h08
`define SOBEL_REG_DSM     8'h0C
`define SOBEL_REG_LINES   8'h10

`endif

// ==== sobel_pkg.sv ====
// Shared types for the edge filter design, imported by the RTL blocks and the testbench.
`include "sobel_macros.svh"

package sobel_pkg;

  localparam int LINE_PIXELS = `SOBEL_LINE_BITS / 8;

  // addresses count whole 64-byte lines, not bytes.
  typedef logic [31:0] line_addr_t;

  // pixel 0 sits in the low byte of the line.
  typedef logic [LINE_PIXELS-1:0][7:0] pixel_line_t;

  // done is bit 0, the line count is bits 32:1, the rest is zero.
  typedef struct packed {
    logic [`SOBEL_LINE_BITS-34:0] pad;
    logic [31:0]                  lines;
    logic                         done;
  } completion_t;

  // the write data word is either a filtered line or the status record.
  typedef union packed {
    pixel_line_t line;
    completion_t completion;
  } write_word_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_FINISH
  } rd_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_COMPLETION,
    WR_FINISH
  } wr_state_t;

endpackage

// ==== sobel_fifo_if.sv ====
// Line FIFO connection between the edge filter, the line FIFO and the requestor.
`timescale 1ns/1ps
`include "sobel_macros.svh"

interface sobel_fifo_if;
  import sobel_pkg::*;

  pixel_line_t enq_data;
  logic        enq_en;
  logic        deq_en;
  pixel_line_t deq_data; // head of the FIFO, valid while not_empty is set.
  logic        not_empty;
  logic        not_full;
  logic [$clog2(`SOBEL_FIFO_DEPTH):0] count;

  modport writer (output enq_data, output enq_en, input not_full);

  modport reader (output deq_en, input deq_data, input not_empty, input count);

  modport owner (
    input  enq_data, enq_en, deq_en,
    output deq_data, not_empty, not_full, count
  );

endinterface

// ==== sobel_credit_counter.sv ====
// Up/down in-flight counter with limit and zero flags, used for read and write credits.
`timescale 1ns/1ps

module sobel_credit_counter #(
  parameter int LIMIT = 8
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       inc,
  input  logic       dec,
  output logic [7:0] count,
  output logic       at_limit,
  output logic       empty
);

  assign at_limit = (count == 8'(LIMIT));
  assign empty    = (count == 8'd0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({inc, dec})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither leave it unchanged.
      endcase
    end
  end

  no_underflow_a: assert property (@(posedge clk) disable iff (reset) dec |-> !empty);

  no_overflow_a: assert property (@(posedge clk) disable iff (reset) inc |-> !at_limit);

endmodule

// ==== sobel_csr.sv ====
// APB register block holding the job settings, issuing start and reporting busy and done.
`timescale 1ns/1ps
`include "sobel_macros.svh"

module sobel_csr (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [7:0]            paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic                  busy,
  input  logic                  done,
  output logic                  start,
  output sobel_pkg::line_addr_t src_base,
  output sobel_pkg::line_addr_t dst_base,
  output sobel_pkg::line_addr_t dsm_base,
  output logic [31:0]           line_count
);
  import sobel_pkg::*;

  logic access;
  logic addr_ok;
  logic wr_en;

  assign access  = psel && penable;
  assign pready  = 1'b1; // no wait states.
  assign pslverr = access && !addr_ok;
  assign wr_en   = access && pwrite && addr_ok;

  always_comb begin
    addr_ok = 1'b1;
    prdata  = '0;
    case (paddr)
      `SOBEL_REG_CONTROL: prdata = {29'd0, done, busy, 1'b0};
      `SOBEL_REG_SRC:     prdata = src_base;
      `SOBEL_REG_DST:     prdata = dst_base;
      `SOBEL_REG_DSM:     prdata = dsm_base;
      `SOBEL_REG_LINES:   prdata = line_count;
      default:            addr_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      start      <= 1'b0;
      src_base   <= '0;
      dst_base   <= '0;
      dsm_base   <= '0;
      line_count <= '0;
    end else begin
      // a start request while a job runs is dropped.
      start <= wr_en && (paddr == `SOBEL_REG_CONTROL) && pwdata[0] && !busy;
      if (wr_en && (paddr == `SOBEL_REG_SRC))   src_base   <= pwdata;
      if (wr_en && (paddr == `SOBEL_REG_DST))   dst_base   <= pwdata;
      if (wr_en && (paddr == `SOBEL_REG_DSM))   dsm_base   <= pwdata;
      if (wr_en && (paddr == `SOBEL_REG_LINES)) line_count <= pwdata;
    end
  end

  start_idle_a: assert property (@(posedge clk) disable iff (reset) $rose(start) |-> !busy);

endmodule

// ==== sobel_requestor.sv ====
// Read and write state machines that fetch source lines, store filtered lines and post status.
`timescale 1ns/1ps
`include "sobel_macros.svh"

module sobel_requestor (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  sobel_pkg::line_addr_t  src_base,
  input  sobel_pkg::line_addr_t  dst_base,
  input  sobel_pkg::line_addr_t  dsm_base,
  input  logic [31:0]            line_count,
  output logic                   busy,
  output logic                   done,
  sobel_fifo_if.reader           fifo,
  output logic                   rd_req_valid,
  output sobel_pkg::line_addr_t  rd_req_addr,
  input  logic                   rd_req_almost_full,
  output logic                   wr_req_valid,
  output sobel_pkg::line_addr_t  wr_req_addr,
  output sobel_pkg::write_word_t wr_req_data,
  input  logic                   wr_req_almost_full,
  input  logic                   wr_rsp_valid
);
  import sobel_pkg::*;

  rd_state_t  rd_state;
  rd_state_t  rd_next;
  wr_state_t  wr_state;
  wr_state_t  wr_next;
  line_addr_t rd_offset;
  line_addr_t wr_offset;
  logic       rd_issue;
  logic       wr_issue;
  logic       cmp_issue;
  logic       job_end;
  logic [7:0] rd_count;
  logic       rd_at_limit;
  logic       wr_at_limit;
  logic       wr_empty;

  // read credits cover lines in flight plus lines waiting in the FIFO.
  sobel_credit_counter #(.LIMIT(`SOBEL_FIFO_DEPTH)) rd_credits (
    .clk      (clk),
    .reset    (reset),
    .inc      (rd_issue),
    .dec      (fifo.deq_en),
    .count    (rd_count),
    .at_limit (rd_at_limit),
    .empty    ()
  );

  sobel_credit_counter #(.LIMIT(`SOBEL_MAX_WRITES)) wr_credits (
    .clk      (clk),
    .reset    (reset),
    .inc      (wr_issue || cmp_issue),
    .dec      (wr_rsp_valid),
    .count    (),
    .at_limit (wr_at_limit),
    .empty    (wr_empty)
  );

  assign fifo.deq_en = wr_issue; // the head line moves into the write registers.

  always_comb begin
    rd_next   = rd_state;
    wr_next   = wr_state;
    rd_issue  = 1'b0;
    wr_issue  = 1'b0;
    cmp_issue = 1'b0;
    job_end   = 1'b0;
    case (wr_state)
      WR_IDLE: if (start && !busy) wr_next = WR_DATA;
      WR_DATA: begin
        if (wr_offset == line_count) wr_next = WR_COMPLETION;
        else wr_issue = fifo.not_empty && !wr_at_limit && !wr_req_almost_full;
      end
      WR_COMPLETION: begin
        // the status record waits until every line write is acknowledged.
        if (wr_empty && !wr_req_almost_full) begin
          cmp_issue = 1'b1;
          wr_next   = WR_FINISH;
        end
      end
      default: begin
        if (wr_empty) begin
          job_end = 1'b1;
          wr_next = WR_IDLE;
        end
      end
    endcase
    case (rd_state)
      RD_IDLE: if (start && !busy) rd_next = RD_FETCH;
      RD_FETCH: begin
        if (rd_offset == line_count) rd_next = RD_FINISH;
        else rd_issue = !rd_at_limit && !rd_req_almost_full;
      end
      default: if (job_end) rd_next = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state     <= RD_IDLE;
      wr_state     <= WR_IDLE;
      rd_offset    <= '0;
      wr_offset    <= '0;
      rd_req_valid <= 1'b0;
      wr_req_valid <= 1'b0;
      busy         <= 1'b0;
      done         <= 1'b0;
    end else begin
      rd_state     <= rd_next;
      wr_state     <= wr_next;
      rd_req_valid <= rd_issue;
      wr_req_valid <= wr_issue || cmp_issue;
      if (start && !busy) begin
        rd_offset <= '0;
        wr_offset <= '0;
        busy      <= 1'b1;
        done      <= 1'b0;
      end
      if (rd_issue) rd_offset <= rd_offset + 1'b1;
      if (wr_issue) wr_offset <= wr_offset + 1'b1;
      if (job_end) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_issue) rd_req_addr <= src_base + rd_offset;
    if (wr_issue) begin
      wr_req_addr      <= dst_base + wr_offset;
      wr_req_data.line <= fifo.deq_data;
    end else if (cmp_issue) begin
      wr_req_addr            <= dsm_base;
      wr_req_data.completion <= '{pad: '0, lines: line_count, done: 1'b1};
    end
  end

  deq_not_empty_a: assert property (@(posedge clk) disable iff (reset)
    fifo.deq_en |-> (fifo.count != 0));

  // lines held in the FIFO were all paid for by a read credit.
  fifo_credit_a: assert property (@(posedge clk) disable iff (reset)
    rd_count >= 8'(fifo.count));

endmodule

// ==== sobel_line_fifo.sv ====
// Circular buffer of filtered lines between the edge filter and the write machine.
`timescale 1ns/1ps
`include "sobel_macros.svh"

module sobel_line_fifo (
  input  logic        clk,
  input  logic        reset,
  sobel_fifo_if.owner fifo
);
  import sobel_pkg::*;

  localparam int PTR_BITS = $clog2(`SOBEL_FIFO_DEPTH);

  pixel_line_t         mem [`SOBEL_FIFO_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   level;
  logic                do_enq;
  logic                do_deq;

  assign do_enq = fifo.enq_en && fifo.not_full;
  assign do_deq = fifo.deq_en && fifo.not_empty;

  assign fifo.deq_data  = mem[rd_ptr];
  assign fifo.not_empty = (level != '0);
  assign fifo.not_full  = (level != (PTR_BITS+1)'(`SOBEL_FIFO_DEPTH));
  assign fifo.count     = level;

  always_ff @(posedge clk) begin
    if (do_enq) mem[wr_ptr] <= fifo.enq_data;
  end

  // the depth is a power of two, so the pointers wrap on their own.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_enq) wr_ptr <= wr_ptr + 1'b1;
      if (do_deq) rd_ptr <= rd_ptr + 1'b1;
      case ({do_enq, do_deq})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  no_enq_full_a: assert property (@(posedge clk) disable iff (reset)
    fifo.enq_en |-> fifo.not_full);

endmodule

// ==== sobel_edge_filter.sv ====
// Registered horizontal gradient filter applied to each line returned by memory.
`timescale 1ns/1ps

module sobel_edge_filter (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  rd_rsp_valid,
  input  sobel_pkg::pixel_line_t rd_rsp_data,
  sobel_fifo_if.writer          fifo
);
  import sobel_pkg::*;

  pixel_line_t grad;

  // the two edge pixels have only one neighbour and stay zero.
  always_comb begin
    grad = '0;
    for (int i = 1; i < LINE_PIXELS - 1; i++) begin
      if (rd_rsp_data[i+1] >= rd_rsp_data[i-1]) grad[i] = rd_rsp_data[i+1] - rd_rsp_data[i-1];
      else grad[i] = rd_rsp_data[i-1] - rd_rsp_data[i+1];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fifo.enq_en <= 1'b0;
    end else begin
      fifo.enq_en <= rd_rsp_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_rsp_valid) fifo.enq_data <= grad;
  end

  // read credits reserve a FIFO slot before the line is requested.
  slot_reserved_a: assert property (@(posedge clk) disable iff (reset)
    rd_rsp_valid |=> fifo.not_full);

endmodule

// ==== sobel_top.sv ====
// Top level of the edge filter accelerator with plain APB and memory request ports.
`timescale 1ns/1ps

module sobel_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [7:0]             paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   rd_req_valid,
  output sobel_pkg::line_addr_t  rd_req_addr,
  input  logic                   rd_req_almost_full,
  input  logic                   rd_rsp_valid,
  input  sobel_pkg::pixel_line_t rd_rsp_data,
  output logic                   wr_req_valid,
  output sobel_pkg::line_addr_t  wr_req_addr,
  output sobel_pkg::write_word_t wr_req_data,
  input  logic                   wr_req_almost_full,
  input  logic                   wr_rsp_valid
);

  logic                  start;
  logic                  busy;
  logic                  done;
  sobel_pkg::line_addr_t src_base;
  sobel_pkg::line_addr_t dst_base;
  sobel_pkg::line_addr_t dsm_base;
  logic [31:0]           line_count;

  sobel_fifo_if fifo_bus ();

  sobel_csr u_csr (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .busy       (busy),
    .done       (done),
    .start      (start),
    .src_base   (src_base),
    .dst_base   (dst_base),
    .dsm_base   (dsm_base),
    .line_count (line_count)
  );

  sobel_requestor u_requestor (
    .clk                (clk),
    .reset              (reset),
    .start              (start),
    .src_base           (src_base),
    .dst_base           (dst_base),
    .dsm_base           (dsm_base),
    .line_count         (line_count),
    .busy               (busy),
    .done               (done),
    .fifo               (fifo_bus.reader),
    .rd_req_valid       (rd_req_valid),
    .rd_req_addr        (rd_req_addr),
    .rd_req_almost_full (rd_req_almost_full),
    .wr_req_valid       (wr_req_valid),
    .wr_req_addr        (wr_req_addr),
    .wr_req_data        (wr_req_data),
    .wr_req_almost_full (wr_req_almost_full),
    .wr_rsp_valid       (wr_rsp_valid)
  );

  sobel_edge_filter u_edge_filter (
    .clk          (clk),
    .reset        (reset),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_data  (rd_rsp_data),
    .fifo         (fifo_bus.writer)
  );

  sobel_line_fifo u_line_fifo (
    .clk   (clk),
    .reset (reset),
    .fifo  (fifo_bus.owner)
  );

endmodule

// ==== sobel_tb_mem.sv ====
// Memory model for the edge filter testbench, with random response latency and almost-full throttling.
`timescale 1ns/1ps

module sobel_tb_mem (
  input  logic                   clk,
  input  logic                   reset,
  input  int                     af_percent,
  input  int                     max_latency,
  input  logic                   rd_req_valid,
  input  sobel_pkg::line_addr_t  rd_req_addr,
  output logic                   rd_req_almost_full,
  output logic                   rd_rsp_valid,
  output sobel_pkg::pixel_line_t rd_rsp_data,
  input  logic                   wr_req_valid,
  input  sobel_pkg::line_addr_t  wr_req_addr,
  input  sobel_pkg::write_word_t wr_req_data,
  output logic                   wr_req_almost_full,
  output logic                   wr_rsp_valid
);
  import sobel_pkg::*;

  logic [511:0] mem [bit [31:0]];
  logic [31:0]  seed = 32'h13fd0422;
  longint       cycle;
  longint       due;
  longint       last_rd_due;
  longint       rd_due [$];
  logic [31:0]  rd_addr [$];
  longint       wr_due [$];
  int           inflight;
  int           max_inflight;
  int           acks_sent;
  logic [31:0]  wr_addr_log [$];
  int           ack_log [$]; // acks already sent when each write arrived.

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int pick(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:8] % n); // the low bits of an LCG repeat quickly.
  endfunction

  // lines never written return a pattern built from the whole address.
  function automatic logic [511:0] read_line(input logic [31:0] addr);
    if (mem.exists(addr)) return mem[addr];
    return {16{addr ^ 32'hc3a5_0f96}};
  endfunction

  function automatic int log_size();
    return wr_addr_log.size();
  endfunction

  function automatic logic [31:0] log_addr(input int i);
    return wr_addr_log[i];
  endfunction

  function automatic int log_acks(input int i);
    return ack_log[i];
  endfunction

  task automatic load_random(input logic [31:0] base, input int lines);
    logic [511:0] line;
    for (int i = 0; i < lines; i++) begin
      for (int w = 0; w < 16; w++) line[32*w +: 32] = lcg_next();
      mem[base + i] = line;
    end
  endtask

  task automatic clear_log();
    acks_sent = 0;
    max_inflight = 0;
    wr_addr_log.delete();
    ack_log.delete();
  endtask

  initial begin
    rd_req_almost_full = 1'b0;
    wr_req_almost_full = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_data = '0;
    wr_rsp_valid = 1'b0;
  end

  // requests are sampled mid-cycle and responses change on the same falling edge.
  always @(negedge clk) begin
    if (reset) begin
      rd_req_almost_full = 1'b0;
      wr_req_almost_full = 1'b0;
      rd_rsp_valid = 1'b0;
      wr_rsp_valid = 1'b0;
      cycle = 0;
      last_rd_due = 0;
      inflight = 0;
      rd_due.delete();
      rd_addr.delete();
      wr_due.delete();
    end else begin
      cycle++;
      if (rd_req_valid) begin
        due = cycle + 1 + pick(max_latency);
        if (due <= last_rd_due) due = last_rd_due + 1; // read data comes back in order.
        last_rd_due = due;
        rd_due.push_back(due);
        rd_addr.push_back(rd_req_addr);
      end
      if (wr_req_valid) begin
        mem[wr_req_addr] = wr_req_data;
        wr_addr_log.push_back(wr_req_addr);
        ack_log.push_back(acks_sent);
        wr_due.push_back(cycle + 1 + pick(max_latency));
        inflight++;
        if (inflight > max_inflight) max_inflight = inflight;
      end
      rd_rsp_valid = 1'b0;
      if (rd_due.size() > 0 && rd_due[0] <= cycle) begin
        rd_rsp_valid = 1'b1;
        rd_rsp_data = read_line(rd_addr.pop_front());
        void'(rd_due.pop_front());
      end
      wr_rsp_valid = 1'b0;
      if (wr_due.size() > 0 && wr_due[0] <= cycle) begin
        wr_rsp_valid = 1'b1;
        void'(wr_due.pop_front());
        inflight--;
        acks_sent++;
      end
      rd_req_almost_full = pick(100) < af_percent;
      wr_req_almost_full = pick(100) < af_percent;
    end
  end

endmodule

// ==== sobel_tb.sv ====
// Testbench top that programs filter jobs over APB and checks memory against a reference model.
`timescale 1ns/1ps
`include "sobel_macros.svh"

module sobel_tb;
  import sobel_pkg::*;

  localparam int MAX_POLLS = 2000;

  logic        clk = 1'b0;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        rd_req_valid;
  line_addr_t  rd_req_addr;
  logic        rd_req_almost_full;
  logic        rd_rsp_valid;
  pixel_line_t rd_rsp_data;
  logic        wr_req_valid;
  line_addr_t  wr_req_addr;
  write_word_t wr_req_data;
  logic        wr_req_almost_full;
  logic        wr_rsp_valid;
  int          af_percent;
  int          max_latency;
  int          errors = 0;
  int          checks = 0;
  logic        last_err;
  logic [31:0] data;
  logic        job_ok;

  always #20 clk = ~clk;

  sobel_top uut (.*);

  sobel_tb_mem mem_model (.*);

  // each inner pixel is the absolute difference of its two neighbours.
  function automatic logic [511:0] edge_ref(input logic [511:0] src);
    logic [511:0] result;
    logic [7:0]   left;
    logic [7:0]   right;
    result = '0;
    for (int i = 1; i < 63; i++) begin
      left = src[8*(i-1) +: 8];
      right = src[8*(i+1) +: 8];
      result[8*i +: 8] = (right > left) ? right - left : left - right;
    end
    return result;
  endfunction

  task automatic check(input logic [511:0] got, input logic [511:0] expected, input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    rdata = prdata; // values from before the edge that ends the access.
    last_err = pslverr;
    check(pready, 1'b1, "pready in the access phase");
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    apb_access(1'b1, addr, wdata, unused);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
    apb_access(1'b0, addr, '0, rdata);
  endtask

  task automatic start_job(input logic [31:0] src, dst, dsm, input int lines);
    apb_write(`SOBEL_REG_SRC, src);
    apb_write(`SOBEL_REG_DST, dst);
    apb_write(`SOBEL_REG_DSM, dsm);
    apb_write(`SOBEL_REG_LINES, lines);
    mem_model.clear_log();
    apb_write(`SOBEL_REG_CONTROL, 32'h1);
  endtask

  task automatic wait_done(input string job, output logic ok);
    logic [31:0] status;
    int          polls;
    polls = 0;
    status = '0;
    while (!status[2] && polls < MAX_POLLS) begin
      apb_read(`SOBEL_REG_CONTROL, status);
      polls++;
    end
    ok = status[2];
    if (!ok) begin
      errors++;
      $display("Timeout: the %s did not report done after %0d status reads", job, polls);
    end
  endtask

  task automatic check_job(input logic [31:0] src, dst, dsm, input int lines);
    logic [511:0] got;
    write_word_t  status;
    int           last;
    for (int i = 0; i < lines; i++) begin
      got = mem_model.read_line(dst + i);
      check(got, edge_ref(mem_model.read_line(src + i)), $sformatf("line %0d at %0h", i, dst + i));
      check(got[7:0], 0, $sformatf("pixel 0 of line %0d", i));
      check(got[511:504], 0, $sformatf("pixel 63 of line %0d", i));
    end
    status = mem_model.read_line(dsm);
    check(status.completion.done, 1'b1, "completion done bit");
    check(status.completion.lines, lines, "completion line count");
    last = mem_model.log_size() - 1;
    check(last + 1, lines + 1, "writes seen in the job");
    check(mem_model.log_addr(last), dsm, "last write address");
    check(mem_model.log_acks(last), lines, "data writes acknowledged before the status write");
  endtask

  initial begin
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    af_percent = 0;
    max_latency = 6;
    job_ok = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    @(negedge clk);
    check(rd_req_valid, 1'b0, "rd_req_valid after reset");
    check(wr_req_valid, 1'b0, "wr_req_valid after reset");
    apb_read(`SOBEL_REG_CONTROL, data);
    check(data[2:1], 2'b00, "busy and done after reset");

    mem_model.load_random(32'h1000, 20);
    start_job(32'h1000, 32'h2000, 32'h3000, 20);
    wait_done("20-line job", job_ok);
    if (job_ok) check_job(32'h1000, 32'h2000, 32'h3000, 20);

    if (job_ok) begin
      // heavy throttling on both channels and slow reads.
      af_percent = 60;
      max_latency = 16;
      mem_model.load_random(32'h4000, 40);
      start_job(32'h4000, 32'h5000, 32'h3100, 40);
      wait_done("40-line job", job_ok);
      if (job_ok) begin
        check_job(32'h4000, 32'h5000, 32'h3100, 40);
        check(mem_model.max_inflight > `SOBEL_MAX_WRITES, 1'b0, "writes in flight above the limit");
      end
    end

    if (job_ok) begin
      af_percent = 20;
      max_latency = 6;
      apb_read(8'h14, data);
      check(last_err, 1'b1, "pslverr on read of offset 0x14");
      apb_write(8'h14, 32'h1);
      check(last_err, 1'b1, "pslverr on write of offset 0x14");
      mem_model.load_random(32'h6000, 12);
      start_job(32'h6000, 32'h7000, 32'h3200, 12);
      apb_write(`SOBEL_REG_CONTROL, 32'h1); // dropped while the job runs.
      wait_done("12-line job", job_ok);
      if (job_ok) check_job(32'h6000, 32'h7000, 32'h3200, 12);
    end

    if (job_ok) begin
      mem_model.load_random(32'h8000, 6);
      start_job(32'h8000, 32'h9000, 32'h3300, 6);
      apb_read(`SOBEL_REG_CONTROL, data);
      check(data[2], 1'b0, "done cleared by start");
      wait_done("second job after done", job_ok);
      if (job_ok) check_job(32'h8000, 32'h9000, 32'h3300, 6);
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
sobel_pkg.sv
sobel_fifo_if.sv
sobel_credit_counter.sv
sobel_csr.sv
sobel_requestor.sv
sobel_line_fifo.sv
sobel_edge_filter.sv
sobel_top.sv
sobel_tb_mem.sv
sobel_tb.sv
